// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// machine word width.
`define XLEN 32

// integer register count.
`define NREGS 32

// bits needed to index one register.
`define REG_AW 5

// first fetch address out of reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] data_t;
  typedef logic [`REG_AW-1:0] reg_adr_t;

  // base opcodes of the supported subset.
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_t;

  typedef enum logic [1:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_writeback
  } fsm_state_t;

  typedef struct packed {
    logic alu_src_imm;
    logic reg_write;
    logic is_branch;
    logic branch_ne;
    logic is_jal;
    logic is_lui;
  } ctrl_t;

  // everything execute needs from decode.
  typedef struct packed {
    ctrl_t    ctrl;
    alu_op_t  alu_op;
    reg_adr_t rd;
    data_t    rd1;
    data_t    rd2;
    data_t    imm_ext;
    data_t    pc;
  } id_ex_t;

  typedef struct packed {
    data_t    pc;
    reg_adr_t rd;
    logic     reg_write;
    data_t    value;
  } commit_t;

endpackage

// ==== pc_counter.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module pc_counter
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  pc_update,
  input  data_t next_pc,
  output data_t pc,
  output data_t instret
);

  // one retirement per pc update.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= `RESET_PC;
      instret <= '0;
    end else if (pc_update) begin
      pc      <= next_pc;
      instret <= instret + 1'b1;
    end
  end

endmodule

// ==== control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  opcode_t    opcode,
  output fsm_state_t state,
  output logic       ir_write,
  output logic       ex_load,
  output logic       wb_load,
  output logic       pc_update,
  output ctrl_t      ctrl
);

  fsm_state_t state_next;

  always_comb begin
    case (state)
      st_fetch:     state_next = st_decode;
      st_decode:    state_next = st_execute;
      st_execute:   state_next = st_writeback;
      default:      state_next = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
    end else begin
      state <= state_next;
    end
  end

  // one strobe per state.
  assign ir_write  = (state == st_fetch);
  assign ex_load   = (state == st_decode);
  assign wb_load   = (state == st_execute);
  assign pc_update = (state == st_writeback);

  // control word per opcode.
  // branch_ne depends on funct3 and comes from decode_stage.
  always_comb begin
    ctrl = '0;
    case (opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
      end
      op_imm: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_lui    = 1'b1;
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
  import rv_pkg::*;
(
  input  data_t    instr,
  output opcode_t  opcode,
  output reg_adr_t rd,
  output reg_adr_t rs1,
  output reg_adr_t rs2,
  output alu_op_t  alu_op,
  output data_t    imm_ext
);

  logic [2:0] funct3;

  assign opcode = opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct3 = instr[14:12];

  // immediate format follows the opcode.
  always_comb begin
    case (opcode)
      op_imm:    imm_ext = {{20{instr[31]}}, instr[31:20]};
      op_lui:    imm_ext = {instr[31:12], 12'b0};
      op_branch: imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      op_jal:    imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
      default:   imm_ext = '0;
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    case (opcode)
      op_reg, op_imm: begin
        case (funct3)
          // funct7 bit 5 selects sub, register form only.
          3'b000:  alu_op = (opcode == op_reg && instr[30]) ? alu_sub : alu_add;
          3'b001:  alu_op = (opcode == op_reg) ? alu_sll : alu_add;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: alu_op = alu_add;
        endcase
      end
      op_branch: alu_op = alu_sub;
      default:   alu_op = alu_add;
    endcase
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_adr_t rs1,
  input  reg_adr_t rs2,
  input  reg_adr_t rd,
  input  logic     we,
  input  data_t    wdata,
  output data_t    rd1,
  output data_t    rd2
);

  data_t regs [`NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 hardwired.
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  data_t    instr,
  input  data_t    pc,
  input  data_t    wb_value,
  input  reg_adr_t wb_rd,
  output id_ex_t   id_ex,
  output logic     ir_write,
  output logic     wb_load,
  output logic     pc_update,
  output logic     reg_write
);

  data_t      ir;
  opcode_t    opcode;
  fsm_state_t state;
  logic       ex_load;
  ctrl_t      ctrl;
  ctrl_t      ctrl_full;
  reg_adr_t   rd;
  reg_adr_t   rs1;
  reg_adr_t   rs2;
  alu_op_t    alu_op;
  data_t      imm_ext;
  data_t      rd1;
  data_t      rd2;

  // the instruction register loads at the end of fetch.
  always_ff @(posedge clk) begin
    if (ir_write) begin
      ir <= instr;
    end
  end

  control_fsm fsm_i (
    .clk       (clk),
    .reset     (reset),
    .opcode    (opcode),
    .state     (state),
    .ir_write  (ir_write),
    .ex_load   (ex_load),
    .wb_load   (wb_load),
    .pc_update (pc_update),
    .ctrl      (ctrl)
  );

  instr_decode dec_i (
    .instr   (ir),
    .opcode  (opcode),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .alu_op  (alu_op),
    .imm_ext (imm_ext)
  );

  // write only in writeback, from the latched control word.
  assign reg_write = (state == st_writeback) && id_ex.ctrl.reg_write;

  reg_file rf_i (
    .clk   (clk),
    .reset (reset),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (wb_rd),
    .we    (reg_write),
    .wdata (wb_value),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  // funct3 bit 0 picks bne over beq.
  always_comb begin
    ctrl_full           = ctrl;
    ctrl_full.branch_ne = ctrl.is_branch & ir[12];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else if (ex_load) begin
      id_ex.ctrl    <= ctrl_full;
      id_ex.alu_op  <= alu_op;
      id_ex.rd      <= rd;
      id_ex.rd1     <= rd1;
      id_ex.rd2     <= rd2;
      id_ex.imm_ext <= imm_ext;
      id_ex.pc      <= pc;
    end
  end

endmodule

// ==== execute_alu.sv ====
`timescale 1ns/1ps

module execute_alu
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   wb_load,
  input  id_ex_t id_ex,
  output data_t  wb_value,
  output data_t  next_pc
);

  data_t op_b;
  data_t alu_result;
  data_t pc_plus4;
  data_t target;
  logic  equal;
  logic  taken;

  assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : id_ex.rd2;

  always_comb begin
    alu_result = '0;
    case (id_ex.alu_op)
      alu_add: alu_result = id_ex.rd1 + op_b;
      alu_sub: alu_result = id_ex.rd1 - op_b;
      alu_and: alu_result = id_ex.rd1 & op_b;
      alu_or:  alu_result = id_ex.rd1 | op_b;
      alu_xor: alu_result = id_ex.rd1 ^ op_b;
      alu_slt: alu_result[0] = $signed(id_ex.rd1) < $signed(op_b);
      alu_sll: alu_result = id_ex.rd1 << op_b[4:0];
      default: alu_result = id_ex.rd1 + op_b;
    endcase
  end

  // branches subtract, so a zero result means equal.
  assign equal    = (alu_result == '0);
  assign taken    = id_ex.ctrl.is_branch & (equal ^ id_ex.ctrl.branch_ne);
  assign pc_plus4 = id_ex.pc + 32'd4;
  assign target   = id_ex.pc + id_ex.imm_ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_value <= '0;
      next_pc  <= '0;
    end else if (wb_load) begin
      wb_value <= id_ex.ctrl.is_jal ? pc_plus4 :
                  id_ex.ctrl.is_lui ? id_ex.imm_ext : alu_result;
      next_pc  <= (taken || id_ex.ctrl.is_jal) ? target : pc_plus4;
    end
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  data_t   instr,
  output data_t   pc,
  output logic    commit_valid,
  output commit_t commit,
  output data_t   instret
);

  id_ex_t id_ex;
  data_t  wb_value;
  data_t  next_pc;
  logic   wb_load;
  logic   pc_update;

  pc_counter pc_i (
    .clk       (clk),
    .reset     (reset),
    .pc_update (pc_update),
    .next_pc   (next_pc),
    .pc        (pc),
    .instret   (instret)
  );

  decode_stage decode_i (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .pc        (pc),
    .wb_value  (wb_value),
    .wb_rd     (id_ex.rd),
    .id_ex     (id_ex),
    .ir_write  (),
    .wb_load   (wb_load),
    .pc_update (pc_update),
    .reg_write ()
  );

  execute_alu exec_i (
    .clk      (clk),
    .reset    (reset),
    .wb_load  (wb_load),
    .id_ex    (id_ex),
    .wb_value (wb_value),
    .next_pc  (next_pc)
  );

  // retirement is the writeback cycle.
  assign commit_valid     = pc_update;
  assign commit.pc        = id_ex.pc;
  assign commit.rd        = id_ex.rd;
  assign commit.reg_write = id_ex.ctrl.reg_write;
  assign commit.value     = wb_value;

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 40 ns period.
  localparam int half_period = 20;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  localparam data_t nop_word  = 32'h0000_0013;
  localparam int    max_wait  = 20;
  localparam int    mem_words = 512;

  logic    clk;
  logic    reset;
  data_t   instr;
  data_t   pc;
  logic    commit_valid;
  commit_t commit;
  data_t   instret;

  data_t   trace_mem [mem_words];
  int      prog_count;
  int      rec_count;
  integer  seed;

  tb_clock clk_i (
    .clk (clk)
  );

  rv_core dut_i (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .pc           (pc),
    .commit_valid (commit_valid),
    .commit       (commit),
    .instret      (instret)
  );

  // program words sit right after the count.
  function automatic data_t fetch_word(data_t addr);
    data_t word;
    word = nop_word;
    if (addr[1:0] == 2'b00 && (addr >> 2) < prog_count) begin
      word = trace_mem[1 + (addr >> 2)];
    end
    return word;
  endfunction

  // instruction memory answers within the fetch cycle.
  always @(negedge clk) begin
    instr <= fetch_word(pc);
  end

  task automatic report_error(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_commit(int idx, commit_t got, commit_t exp);
    if (got !== exp) begin
      report_error($sformatf(
        "commit %0d pc=%h rd=%0d we=%b value=%h, expected pc=%h rd=%0d we=%b value=%h",
        idx, got.pc, got.rd, got.reg_write, got.value,
        exp.pc, exp.rd, exp.reg_write, exp.value));
    end
  endtask

  task automatic check_instret(data_t got, data_t exp);
    if (got !== exp) begin
      report_error($sformatf("instret is %0d, expected %0d", got, exp));
    end
  endtask

  task automatic check_pc(data_t got, data_t exp);
    if (got !== exp) begin
      report_error($sformatf("pc is %h, expected %h", got, exp));
    end
  endtask

  // counts cycles from the current one up to the commit cycle.
  task automatic wait_commit(output int cycles);
    cycles = 1;
    while (commit_valid !== 1'b1) begin
      if (cycles >= max_wait) begin
        $display("Timeout: no commit seen within %0d cycles", max_wait);
        $display("Test failed");
        $fatal(1, "commit wait timed out");
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  initial begin
    commit_t exp;
    int      base;
    int      idle;
    int      cycles;
    int      rec;
    seed  = 8437;
    reset = 1'b1;
    instr = nop_word;
    $readmemh("core_trace.txt", trace_mem);
    if (^trace_mem[0] === 1'bx) begin
      $display("Could not read the program count from core_trace.txt");
      $display("Test failed");
      $fatal(1, "trace file missing");
    end
    prog_count = trace_mem[0];
    rec_count  = trace_mem[1 + prog_count];
    base       = 2 + prog_count;

    // a few extra idle reset cycles.
    idle = $unsigned($random(seed)) % 4;
    repeat (2 + idle) @(negedge clk);
    reset = 1'b0;
    check_pc(pc, 32'h0);

    for (int i = 0; i < rec_count; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      wait_commit(cycles);
      if (cycles != 4) begin
        report_error($sformatf("commit %0d came in cycle %0d, expected cycle 4", i, cycles));
      end
      rec           = base + 4 * i;
      exp.pc        = trace_mem[rec];
      exp.rd        = trace_mem[rec + 1][4:0];
      exp.reg_write = trace_mem[rec + 2][0];
      exp.value     = trace_mem[rec + 3];
      check_commit(i, commit, exp);
    end

    // instret moves at the edge that ends writeback.
    @(negedge clk);
    check_instret(instret, data_t'(rec_count));
    $display("Test passed");
    $finish;
  end

endmodule

// ==== core_trace.txt ====
// program: word count, then the instruction words
// commits: record count, then one record per line as pc rd reg_write value
19
00500093 FFD00113 002081B3 40208233 0020F2B3
0020E333 0020C3B3 00112433 001094B3 FFF12513
0F017593 12306613 FFF0C693 12345737 ABCDE037
001007B3 00108463 06300813 00109463 00208463
00209463 06300813 008008EF 06300813 00088913
16
00000000 01 1 00000005
00000004 02 1 FFFFFFFD
00000008 03 1 00000002
0000000C 04 1 00000008
00000010 05 1 00000005
00000014 06 1 FFFFFFFD
00000018 07 1 FFFFFFF8
0000001C 08 1 00000001
00000020 09 1 000000A0
00000024 0A 1 00000001
00000028 0B 1 000000F0
0000002C 0C 1 00000123
00000030 0D 1 FFFFFFFA
00000034 0E 1 12345000
00000038 00 1 ABCDE000
0000003C 0F 1 00000005
00000040 08 0 00000000
00000048 08 0 00000000
0000004C 08 0 00000008
00000050 08 0 00000008
00000058 11 1 0000005C
00000060 12 1 0000005C

// ==== compile.f ====
+incdir+.
rv_pkg.sv
pc_counter.sv
control_fsm.sv
instr_decode.sv
reg_file.sv
decode_stage.sv
execute_alu.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv
